/* hw/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // ----------------------------------------
    // widths and opcodes
    // ----------------------------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [6:0] OP_JAL  = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    // ----------------------------------------
    // control encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD   = 3'b000,
        ALU_SUB   = 3'b001,
        ALU_AND   = 3'b010,
        ALU_OR    = 3'b011,
        ALU_XOR   = 3'b100,
        ALU_SLT   = 3'b101,
        ALU_SLTU  = 3'b110,
        ALU_SHIFT = 3'b111
    } alu_ctl_e;

    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00,
        SHIFT_SRL = 2'b01,
        SHIFT_SRA = 2'b10
    } alu_shift_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'b00,
        SRC_A_PC   = 2'b01,
        SRC_A_ZERO = 2'b10 // lui
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_e;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // store funct3
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;

    // ----------------------------------------
    // pipeline payloads
    // ----------------------------------------
    typedef struct packed {
        logic              valid;
        alu_ctl_e          alu_ctl;
        alu_shift_e        alu_shift;
        src_a_e            src_a;
        src_b_e            src_b;
        logic              branch;
        logic              jmp;
        logic              mem_write;
        logic [6:0]        opcode;
        logic [2:0]        f3;
        fwd_e              fw_a;
        fwd_e              fw_b;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   alu_out;
        logic [XLEN-1:0]   pc_p4;
        logic [XLEN-1:0]   next_pc;
        logic              redirect;
        logic              mem_write;
        logic              store_byte;
        logic              store_half;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
    } ex_mem_t;

endpackage

`default_nettype wire

/* hw/stage_reg.sv */
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_en,
    input  logic i_flush,
    input  T     i_d,
    output T     o_q
);

    // zero payload doubles as a bubble, valid low
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_q <= '0;
        end
        else if (i_en)
        begin
            if (i_flush)
                o_q <= '0; // drop the incoming instruction
            else
                o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

/* hw/operand_forward.sv */
`default_nettype none

module operand_forward (
    input  ex_pkg::fwd_e            i_fw_a,
    input  ex_pkg::fwd_e            i_fw_b,
    input  logic [ex_pkg::XLEN-1:0] i_rs1_data,
    input  logic [ex_pkg::XLEN-1:0] i_rs2_data,
    input  logic [ex_pkg::XLEN-1:0] i_mem_fwd,
    input  logic [ex_pkg::XLEN-1:0] i_wb_fwd,
    output logic [ex_pkg::XLEN-1:0] o_rs1,
    output logic [ex_pkg::XLEN-1:0] o_rs2
);

    import ex_pkg::*;

    // memory stage result wins over write-back
    function automatic logic [XLEN-1:0] pick(
        input fwd_e            code,
        input logic [XLEN-1:0] reg_data,
        input logic [XLEN-1:0] mem_data,
        input logic [XLEN-1:0] wb_data
    );
        logic [XLEN-1:0] res;
        case (code)
            FWD_MEM:
                res = mem_data;
            FWD_WB:
                res = wb_data;
            default:
                res = reg_data; // FWD_NONE and the unused code
        endcase
        return res;
    endfunction

    always_comb
    begin
        o_rs1 = pick(i_fw_a, i_rs1_data, i_mem_fwd, i_wb_fwd);
        o_rs2 = pick(i_fw_b, i_rs2_data, i_mem_fwd, i_wb_fwd);
    end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`default_nettype none

module alu_unit (
    input  ex_pkg::alu_ctl_e        i_ctl,
    input  ex_pkg::alu_shift_e      i_shift,
    input  ex_pkg::src_a_e          i_src_a,
    input  ex_pkg::src_b_e          i_src_b,
    input  logic [ex_pkg::XLEN-1:0] i_rs1,
    input  logic [ex_pkg::XLEN-1:0] i_rs2,
    input  logic [ex_pkg::XLEN-1:0] i_pc,
    input  logic [ex_pkg::XLEN-1:0] i_imm,
    output logic [ex_pkg::XLEN-1:0] o_alu_out
);

    import ex_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] shift_res;
    logic [4:0]      shamt;

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    always_comb
    begin
        case (i_src_a)
            SRC_A_RS1:
                op_a = i_rs1;
            SRC_A_PC:
                op_a = i_pc; // auipc, jal
            SRC_A_ZERO:
                op_a = '0;
            default:
                op_a = '0;
        endcase
    end

    assign op_b  = (i_src_b == SRC_B_IMM) ? i_imm : i_rs2;
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (i_shift)
            SHIFT_SLL:
                shift_res = op_a << shamt;
            SHIFT_SRL:
                shift_res = op_a >> shamt;
            SHIFT_SRA:
                shift_res = $unsigned($signed(op_a) >>> shamt);
            default:
                shift_res = '0;
        endcase
    end

    // ----------------------------------------
    // operations
    // ----------------------------------------
    always_comb
    begin
        case (i_ctl)
            ALU_ADD:
                o_alu_out = op_a + op_b;
            ALU_SUB:
                o_alu_out = op_a - op_b;
            ALU_AND:
                o_alu_out = op_a & op_b;
            ALU_OR:
                o_alu_out = op_a | op_b;
            ALU_XOR:
                o_alu_out = op_a ^ op_b;
            ALU_SLT:
                o_alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:
                o_alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SHIFT:
                o_alu_out = shift_res;
            default:
                o_alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`default_nettype none

module branch_unit (
    input  logic                    i_branch,
    input  logic [2:0]              i_f3,
    input  logic [ex_pkg::XLEN-1:0] i_rs1,
    input  logic [ex_pkg::XLEN-1:0] i_rs2,
    input  logic [ex_pkg::XLEN-1:0] i_pc,
    input  logic [ex_pkg::XLEN-1:0] i_imm,
    output logic                    o_taken,
    output logic [ex_pkg::XLEN-1:0] o_target,
    output logic [ex_pkg::XLEN-1:0] o_pc_p4
);

    import ex_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    // own comparator, no wait on the alu
    assign eq   = (i_rs1 == i_rs2);
    assign lt_s = ($signed(i_rs1) < $signed(i_rs2));
    assign lt_u = (i_rs1 < i_rs2);

    always_comb
    begin
        case (i_f3)
            F3_BEQ:
                cond = eq;
            F3_BNE:
                cond = !eq;
            F3_BLT:
                cond = lt_s;
            F3_BGE:
                cond = !lt_s;
            F3_BLTU:
                cond = lt_u;
            F3_BGEU:
                cond = !lt_u;
            default:
                cond = 1'b0; // 010/011 are not branches
        endcase
    end

    assign o_taken  = i_branch && cond;
    assign o_target = i_pc + i_imm; // branch and jal share this adder
    assign o_pc_p4  = i_pc + XLEN'(4);

endmodule

`default_nettype wire

/* hw/ex_result_merge.sv */
`default_nettype none

module ex_result_merge (
    input  ex_pkg::id_ex_t          i_id,
    input  logic [ex_pkg::XLEN-1:0] i_alu_out,
    input  logic [ex_pkg::XLEN-1:0] i_target,
    input  logic [ex_pkg::XLEN-1:0] i_pc_p4,
    input  logic [ex_pkg::XLEN-1:0] i_rs2,
    input  logic                    i_taken,
    output ex_pkg::ex_mem_t         o_ex
);

    import ex_pkg::*;

    typedef enum logic [1:0] {
        PC_SEL_P4     = 2'b00,
        PC_SEL_TARGET = 2'b01,
        PC_SEL_ALU    = 2'b10
    } pc_sel_e;

    pc_sel_e         pc_sel;
    logic [XLEN-1:0] next_pc;

    // ----------------------------------------
    // next pc
    // ----------------------------------------
    always_comb
    begin
        if (i_taken || (i_id.jmp && i_id.opcode == OP_JAL))
            pc_sel = PC_SEL_TARGET;
        else if (i_id.jmp && i_id.opcode == OP_JALR)
            pc_sel = PC_SEL_ALU; // rs1+imm from the alu
        else
            pc_sel = PC_SEL_P4;
    end

    always_comb
    begin
        case (pc_sel)
            PC_SEL_TARGET:
                next_pc = i_target;
            PC_SEL_ALU:
                next_pc = i_alu_out;
            default:
                next_pc = i_pc_p4;
        endcase
    end

    // ----------------------------------------
    // ex/mem payload
    // ----------------------------------------
    always_comb
    begin
        o_ex.valid      = i_id.valid;
        o_ex.alu_out    = i_alu_out;
        o_ex.pc_p4      = i_pc_p4;
        o_ex.next_pc    = next_pc;
        o_ex.redirect   = i_id.valid && (pc_sel != PC_SEL_P4);
        o_ex.mem_write  = i_id.valid && i_id.mem_write;
        o_ex.store_byte = (i_id.f3 == F3_SB); // only meaningful with mem_write
        o_ex.store_half = (i_id.f3 == F3_SH);
        o_ex.store_data = i_rs2;              // forwarded value
        o_ex.rd         = i_id.rd;
    end

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none

module exec_stage (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_clk_en,
    input  logic                      i_flush,
    input  ex_pkg::id_ex_t            i_id,
    input  logic [ex_pkg::XLEN-1:0]   i_wb_result,
    output logic                      o_valid,
    output logic                      o_redirect,
    output logic                      o_mem_write,
    output logic                      o_store_byte,
    output logic                      o_store_half,
    output logic [ex_pkg::XLEN-1:0]   o_alu_out,
    output logic [ex_pkg::XLEN-1:0]   o_pc_p4,
    output logic [ex_pkg::XLEN-1:0]   o_next_pc,
    output logic [ex_pkg::XLEN-1:0]   o_store_data,
    output logic [ex_pkg::REG_AW-1:0] o_rd
);

    import ex_pkg::*;

    id_ex_t          id_ex_q;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] pc_p4;
    logic            br_taken;

    stage_reg #(.T(id_ex_t)) id_ex_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (i_clk_en),
        .i_flush (i_flush),
        .i_d     (i_id),
        .o_q     (id_ex_q)
    );

    // ----------------------------------------
    // execute
    // ----------------------------------------
    operand_forward fwd_inst (
        .i_fw_a     (id_ex_q.fw_a),
        .i_fw_b     (id_ex_q.fw_b),
        .i_rs1_data (id_ex_q.rs1_data),
        .i_rs2_data (id_ex_q.rs2_data),
        .i_mem_fwd  (ex_mem_q.alu_out), // previous instruction
        .i_wb_fwd   (i_wb_result),
        .o_rs1      (rs1_fwd),
        .o_rs2      (rs2_fwd)
    );

    alu_unit alu_inst (
        .i_ctl     (id_ex_q.alu_ctl),
        .i_shift   (id_ex_q.alu_shift),
        .i_src_a   (id_ex_q.src_a),
        .i_src_b   (id_ex_q.src_b),
        .i_rs1     (rs1_fwd),
        .i_rs2     (rs2_fwd),
        .i_pc      (id_ex_q.pc),
        .i_imm     (id_ex_q.imm),
        .o_alu_out (alu_out)
    );

    branch_unit br_inst (
        .i_branch (id_ex_q.branch),
        .i_f3     (id_ex_q.f3),
        .i_rs1    (rs1_fwd),
        .i_rs2    (rs2_fwd),
        .i_pc     (id_ex_q.pc),
        .i_imm    (id_ex_q.imm),
        .o_taken  (br_taken),
        .o_target (br_target),
        .o_pc_p4  (pc_p4)
    );

    ex_result_merge merge_inst (
        .i_id      (id_ex_q),
        .i_alu_out (alu_out),
        .i_target  (br_target),
        .i_pc_p4   (pc_p4),
        .i_rs2     (rs2_fwd),
        .i_taken   (br_taken),
        .o_ex      (ex_mem_d)
    );

    stage_reg #(.T(ex_mem_t)) ex_mem_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_en    (i_clk_en),
        .i_flush (1'b0), // no flush past execute
        .i_d     (ex_mem_d),
        .o_q     (ex_mem_q)
    );

    assign o_valid      = ex_mem_q.valid;
    assign o_redirect   = ex_mem_q.redirect;
    assign o_mem_write  = ex_mem_q.mem_write;
    assign o_store_byte = ex_mem_q.store_byte;
    assign o_store_half = ex_mem_q.store_half;
    assign o_alu_out    = ex_mem_q.alu_out;
    assign o_pc_p4      = ex_mem_q.pc_p4;
    assign o_next_pc    = ex_mem_q.next_pc;
    assign o_store_data = ex_mem_q.store_data;
    assign o_rd         = ex_mem_q.rd;

endmodule

`default_nettype wire

/* verif/exec_stage_asserts.sv */
`default_nettype none

module exec_stage_asserts (
    input logic i_clk,
    input logic i_rst,
    input logic i_valid,
    input logic i_redirect,
    input logic i_mem_write,
    input logic i_store_byte,
    input logic i_store_half
);

    timeunit 1ns;
    timeprecision 1ps;

    // only a live instruction may redirect fetch
    redirect_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_rst) i_redirect |-> i_valid
    ) else $error("redirect raised without a valid instruction");

    // a store is byte, half or word, never two at once
    store_size_onehot: assert property (
        @(posedge i_clk) disable iff (i_rst) i_mem_write |-> !(i_store_byte && i_store_half)
    ) else $error("store byte and store half both set on a memory write");

    reset_clears_valid: assert property (
        @(posedge i_clk) i_rst |=> !i_valid
    ) else $error("valid output high in the cycle after reset");

endmodule

`default_nettype wire

/* verif/tb_exec_stage.sv */
`default_nettype none

module tb_exec_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 16;
    localparam int TEST_CYCLES = 400; // per test
    localparam int N_TESTS     = 5;
    localparam int WATCHDOG_NS = (RST_CYCLES + N_TESTS * TEST_CYCLES + 50) * CLK_PERIOD;

    logic              i_clk;
    logic              i_rst;
    logic              i_clk_en;
    logic              i_flush;
    id_ex_t            i_id;
    logic [XLEN-1:0]   i_wb_result;
    logic              o_valid;
    logic              o_redirect;
    logic              o_mem_write;
    logic              o_store_byte;
    logic              o_store_half;
    logic [XLEN-1:0]   o_alu_out;
    logic [XLEN-1:0]   o_pc_p4;
    logic [XLEN-1:0]   o_next_pc;
    logic [XLEN-1:0]   o_store_data;
    logic [REG_AW-1:0] o_rd;

    id_ex_t  m_idex; // model of the id/ex register
    ex_mem_t exp_q;  // expected ex/mem outputs
    string   cur_test;
    int      checks;
    int      errors;
    int      test_errs;
    int      failed_tests;

    exec_stage dut0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_clk_en     (i_clk_en),
        .i_flush      (i_flush),
        .i_id         (i_id),
        .i_wb_result  (i_wb_result),
        .o_valid      (o_valid),
        .o_redirect   (o_redirect),
        .o_mem_write  (o_mem_write),
        .o_store_byte (o_store_byte),
        .o_store_half (o_store_half),
        .o_alu_out    (o_alu_out),
        .o_pc_p4      (o_pc_p4),
        .o_next_pc    (o_next_pc),
        .o_store_data (o_store_data),
        .o_rd         (o_rd)
    );

    bind exec_stage exec_stage_asserts asserts0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (o_valid),
        .i_redirect   (o_redirect),
        .i_mem_write  (o_mem_write),
        .i_store_byte (o_store_byte),
        .i_store_half (o_store_half)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ----------------------------------------
    // stimulus and reference model
    // ----------------------------------------
    // kind 0 alu, 1 forwarding, 2 branch/jump, 3 store, 4 any of them
    function automatic id_ex_t gen_instr(input int kind);
        id_ex_t id;
        int     sel;
        if (kind == 4)
            kind = $urandom_range(3, 0);
        id           = '0;
        id.valid     = 1'b1;
        id.alu_ctl   = alu_ctl_e'(3'($urandom_range(7, 0)));
        id.alu_shift = alu_shift_e'(2'($urandom_range(2, 0)));
        id.src_a     = src_a_e'(2'($urandom_range(2, 0)));
        id.src_b     = src_b_e'(1'($urandom_range(1, 0)));
        id.opcode    = 7'b0110011;
        id.f3        = 3'($urandom);
        id.rd        = 5'($urandom);
        id.pc        = $urandom & 32'hffff_fffc;
        id.imm       = $urandom;
        id.rs1_data  = $urandom;
        id.rs2_data  = ($urandom_range(3, 0) == 0) ? id.rs1_data : $urandom; // equal operands
        case (kind)
            1:
            begin
                id.fw_a = fwd_e'(2'($urandom_range(3, 0))); // 11 behaves as none
                id.fw_b = fwd_e'(2'($urandom_range(3, 0)));
            end
            2:
            begin
                sel       = $urandom_range(2, 0);
                id.branch = (sel == 0);
                id.jmp    = (sel != 0);
                id.alu_ctl = ALU_ADD;
                id.src_a  = (sel == 1) ? SRC_A_PC : SRC_A_RS1;
                id.src_b  = SRC_B_IMM;
                id.opcode = (sel == 0) ? 7'b1100011 : ((sel == 1) ? OP_JAL : OP_JALR);
                id.fw_a   = fwd_e'(2'($urandom_range(3, 0))); // comparator and jalr base
                id.fw_b   = fwd_e'(2'($urandom_range(3, 0)));
            end
            3:
            begin
                id.mem_write = 1'b1;
                id.opcode    = 7'b0100011;
                id.f3        = 3'($urandom_range(2, 0)); // sb, sh, sw
                id.alu_ctl   = ALU_ADD;
                id.src_a     = SRC_A_RS1;
                id.src_b     = SRC_B_IMM;
                id.fw_b      = fwd_e'(2'($urandom_range(2, 0)));
            end
            default:
                id.fw_a = FWD_NONE;
        endcase
        return id;
    endfunction

    function automatic ex_mem_t model_execute(input id_ex_t id, input logic [XLEN-1:0] wb,
                                              input logic [XLEN-1:0] prev_alu);
        ex_mem_t         r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
        logic [4:0]      sh;
        logic            cond;
        logic            jal;
        logic            jalr;
        a   = (id.fw_a == FWD_MEM) ? prev_alu : ((id.fw_a == FWD_WB) ? wb : id.rs1_data);
        b   = (id.fw_b == FWD_MEM) ? prev_alu : ((id.fw_b == FWD_WB) ? wb : id.rs2_data);
        opa = (id.src_a == SRC_A_PC) ? id.pc : ((id.src_a == SRC_A_ZERO) ? '0 : a);
        opb = (id.src_b == SRC_B_IMM) ? id.imm : b;
        sh  = opb[4:0];
        case (id.alu_ctl)
            ALU_ADD:  r.alu_out = opa + opb;
            ALU_SUB:  r.alu_out = opa - opb;
            ALU_AND:  r.alu_out = opa & opb;
            ALU_OR:   r.alu_out = opa | opb;
            ALU_XOR:  r.alu_out = opa ^ opb;
            ALU_SLT:  r.alu_out = ($signed(opa) < $signed(opb)) ? 32'd1 : 32'd0;
            ALU_SLTU: r.alu_out = (opa < opb) ? 32'd1 : 32'd0;
            default:
            begin
                if (id.alu_shift == SHIFT_SLL)
                    r.alu_out = opa << sh;
                else if (id.alu_shift == SHIFT_SRL)
                    r.alu_out = opa >> sh;
                else
                    r.alu_out = (opa >> sh) | (opa[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            end
        endcase
        case (id.f3)
            F3_BEQ:  cond = (a == b);
            F3_BNE:  cond = (a != b);
            F3_BLT:  cond = ($signed(a) < $signed(b));
            F3_BGE:  cond = ($signed(a) >= $signed(b));
            F3_BLTU: cond = (a < b);
            F3_BGEU: cond = (a >= b);
            default: cond = 1'b0;
        endcase
        cond         = cond && id.branch;
        jal          = id.jmp && (id.opcode == OP_JAL);
        jalr         = id.jmp && (id.opcode == OP_JALR);
        r.valid      = id.valid;
        r.pc_p4      = id.pc + 32'd4;
        r.next_pc    = (cond || jal) ? id.pc + id.imm : (jalr ? r.alu_out : r.pc_p4);
        r.redirect   = id.valid && (cond || jal || jalr);
        r.mem_write  = id.valid && id.mem_write;
        r.store_byte = (id.f3 == F3_SB);
        r.store_half = (id.f3 == F3_SH);
        r.store_data = b;
        r.rd         = id.rd;
        return r;
    endfunction

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic check_field(input string field, input logic [XLEN-1:0] want,
                               input logic [XLEN-1:0] got);
        checks++;
        assert (got === want)
        else
        begin
            $display("mismatch %s %s: expected %h, actual %h", cur_test, field, want, got);
            test_errs++;
        end
    endtask

    task automatic compare_outputs();
        check_field("valid", 32'(exp_q.valid), 32'(o_valid));
        check_field("redirect", 32'(exp_q.redirect), 32'(o_redirect));
        check_field("mem_write", 32'(exp_q.mem_write), 32'(o_mem_write));
        check_field("store_byte", 32'(exp_q.store_byte), 32'(o_store_byte));
        check_field("store_half", 32'(exp_q.store_half), 32'(o_store_half));
        check_field("alu_out", exp_q.alu_out, o_alu_out);
        check_field("pc_p4", exp_q.pc_p4, o_pc_p4);
        check_field("next_pc", exp_q.next_pc, o_next_pc);
        check_field("store_data", exp_q.store_data, o_store_data);
        check_field("rd", 32'(exp_q.rd), 32'(o_rd));
    endtask

    task automatic run_test(input string name, input int kind);
        cur_test  = name;
        test_errs = 0;
        repeat (TEST_CYCLES)
        begin
            @(negedge i_clk);
            compare_outputs(); // result of the last rising edge
            i_id        = gen_instr(kind);
            i_wb_result = $urandom;
            i_clk_en    = (kind == 4) ? ($urandom_range(9, 0) < 7) : 1'b1;
            i_flush     = (kind == 4) ? ($urandom_range(9, 0) < 3) : 1'b0;
            if (i_clk_en)
            begin
                exp_q = model_execute(m_idex, i_wb_result, exp_q.alu_out);
                if (i_flush)
                    m_idex = '0;
                else
                    m_idex = i_id;
            end
        end
        errors += test_errs;
        if (test_errs != 0)
            failed_tests++;
        $display("test %-8s done, %0d errors", name, test_errs);
    endtask

    initial
    begin
        void'($urandom(32'h3110));
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_clk_en     = 1'b0;
        i_flush      = 1'b0;
        i_id         = '0;
        i_wb_result  = '0;
        m_idex       = '0;
        exp_q        = '0;
        checks       = 0;
        errors       = 0;
        failed_tests = 0;
        repeat (RST_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;
        run_test("alu", 0);
        run_test("forward", 1);
        run_test("branch", 2);
        run_test("store", 3);
        run_test("flush_en", 4);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 N_TESTS, failed_tests, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #WATCHDOG_NS;
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/ex_pkg.sv
hw/stage_reg.sv
hw/operand_forward.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/ex_result_merge.sv
hw/exec_stage.sv
verif/exec_stage_asserts.sv
verif/tb_exec_stage.sv

/* Makefile */
sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_exec_stage \
		-f verilog.f -o sim_exec
	./obj_dir/sim_exec > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log
